// File: rtl/adc_cmd_pkg.sv
package adc_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // command bytes of the adc
    ////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        CMD_PAD      = 8'h00,
        CMD_RATE_64K = 8'h8F,
        CMD_MODE_SEQ = 8'hBF,
        CMD_WR_CTRL1 = 8'hC2,
        CMD_WR_CTRL2 = 8'hC4,
        CMD_WR_CTRL3 = 8'hC6,
        CMD_WR_GPI   = 8'hC8,
        CMD_WR_SEQ   = 8'hD0,
        CMD_RD_DATA  = 8'hDD
    } adc_cmd_e;

    ////////////////////////////////////////////////////////////
    // configuration table
    ////////////////////////////////////////////////////////////

    localparam int INIT_FRAMES = 8;

    typedef struct packed {
        logic [2:0] len;
        adc_cmd_e   cmd;
        logic [7:0] data;
    } init_frame_t;

    // seq mode 1, ctrl1, ext clock, standby, sync mode, gpio off, rate, mode
    localparam init_frame_t INIT_TABLE [INIT_FRAMES] = '{
        '{3'd2, CMD_WR_SEQ,   8'h03},
        '{3'd2, CMD_WR_CTRL1, 8'h0C},
        '{3'd2, CMD_WR_CTRL2, 8'hA0},
        '{3'd2, CMD_WR_CTRL1, 8'h2C},
        '{3'd2, CMD_WR_CTRL3, 8'h3C},
        '{3'd2, CMD_WR_GPI,   8'h00},
        '{3'd1, CMD_RATE_64K, 8'h00},
        '{3'd1, CMD_MODE_SEQ, 8'h00}
    };

    localparam int SAMPLE_W = 24;

    // command byte plus the sample bytes
    function automatic logic [2:0] read_frame_len(input int unsigned sample_bytes);
        return 3'(sample_bytes + 1);
    endfunction

endpackage

// File: rtl/spi_link_pkg.sv
package spi_link_pkg;

    // byte request from a requester to the engine
    typedef struct packed {
        logic       valid;
        logic       new_frame;
        logic [2:0] frame_len;
        logic [7:0] tx_byte;
    } byte_req_t;

    typedef struct packed {
        logic       done;
        logic [7:0] rx_byte;
    } byte_rsp_t;

    // towards the external spi master
    typedef struct packed {
        logic       rst_n;
        logic [2:0] tx_count;
        logic [7:0] tx_byte;
        logic       tx_dv;
    } spi_mst_out_t;

endpackage

// File: rtl/rdyb_edge_detect.sv
module rdyb_edge_detect #(
    parameter int SYNC_STAGES = 2
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_rdyb,
    output logic o_fall
);

    // sync stages plus one history stage
    logic [SYNC_STAGES:0] sync_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            // rdyb idles high
            sync_q <= '1;
            o_fall <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-1:0], i_rdyb};
            o_fall <= sync_q[SYNC_STAGES] & ~sync_q[SYNC_STAGES-1];
        end
    end

endmodule

// File: rtl/adc_init_sequencer.sv
module adc_init_sequencer (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    input  spi_link_pkg::byte_rsp_t i_rsp,
    output spi_link_pkg::byte_req_t o_req,
    output logic                    o_busy
);

    localparam int IDX_W = $clog2(adc_cmd_pkg::INIT_FRAMES);

    typedef enum logic [1:0] {
        IDLE,
        CMD_BYTE,
        DATA_BYTE
    } state_e;

    state_e                   state;
    logic [IDX_W-1:0]         idx;
    adc_cmd_pkg::init_frame_t frame;
    logic                     last_frame;

    assign frame      = adc_cmd_pkg::INIT_TABLE[idx];
    assign last_frame = (idx == IDX_W'(adc_cmd_pkg::INIT_FRAMES - 1));
    assign o_busy     = (state != IDLE);

    ////////////////////////////////////////////////////////////
    // table walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // start pulses while running fall through here unseen
                    if (i_start) begin
                        idx   <= '0;
                        state <= CMD_BYTE;
                    end
                end
                CMD_BYTE: begin
                    if (i_rsp.done) begin
                        if (frame.len == 3'd2) begin
                            state <= DATA_BYTE;
                        end else if (last_frame) begin
                            state <= IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                DATA_BYTE: begin
                    if (i_rsp.done) begin
                        if (last_frame) begin
                            state <= IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= CMD_BYTE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        o_req = '0;
        case (state)
            CMD_BYTE: begin
                o_req.valid     = 1'b1;
                o_req.new_frame = 1'b1;
                o_req.frame_len = frame.len;
                o_req.tx_byte   = frame.cmd;
            end
            DATA_BYTE: begin
                o_req.valid     = 1'b1;
                o_req.frame_len = frame.len;
                o_req.tx_byte   = frame.data;
            end
            default: o_req = '0;
        endcase
    end

    // request held with stable fields until the engine answers
    a_req_held: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_req.valid && !i_rsp.done) |=> (o_req.valid && $stable(o_req))
    );

endmodule

// File: rtl/adc_sample_reader.sv
module adc_sample_reader #(
    parameter int SAMPLE_BYTES = adc_cmd_pkg::SAMPLE_W / 8
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_rdyb_fall,
    input  logic                        i_en,
    input  logic                        i_init_busy,
    input  spi_link_pkg::byte_rsp_t     i_rsp,
    output spi_link_pkg::byte_req_t     o_req,
    output logic [8*SAMPLE_BYTES-1:0]   o_adc_data,
    output logic                        o_adc_data_dv
);

    localparam int         CNT_W     = $clog2(SAMPLE_BYTES + 1);
    localparam logic [2:0] FRAME_LEN = adc_cmd_pkg::read_frame_len(SAMPLE_BYTES);

    typedef enum logic [1:0] {
        IDLE,
        CMD,
        PAD,
        PUBLISH
    } state_e;

    state_e                    state;
    logic [CNT_W-1:0]          pad_cnt;
    logic                      last_pad;
    logic [8*SAMPLE_BYTES-1:0] samp_sr;
    logic [8*SAMPLE_BYTES-1:0] samp_next;

    assign last_pad  = (pad_cnt == CNT_W'(SAMPLE_BYTES - 1));
    // msb first, so each reply enters at the bottom
    assign samp_next = {samp_sr[8*SAMPLE_BYTES-9:0], i_rsp.rx_byte};

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state      <= IDLE;
            pad_cnt    <= '0;
            o_adc_data <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_rdyb_fall && i_en && !i_init_busy) begin
                        state <= CMD;
                    end
                end
                CMD: begin
                    if (i_rsp.done) begin
                        pad_cnt <= '0;
                        state   <= PAD;
                    end
                end
                PAD: begin
                    if (i_rsp.done) begin
                        if (last_pad) begin
                            o_adc_data <= samp_next;
                            state      <= PUBLISH;
                        end else begin
                            pad_cnt <= pad_cnt + 1'b1;
                        end
                    end
                end
                PUBLISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == PAD && i_rsp.done) begin
            samp_sr <= samp_next;
        end
    end

    assign o_adc_data_dv = (state == PUBLISH);

    always_comb begin
        o_req = '0;
        if (state == CMD || state == PAD) begin
            o_req.valid     = 1'b1;
            o_req.new_frame = (state == CMD);
            o_req.frame_len = FRAME_LEN;
            o_req.tx_byte   = (state == CMD) ? adc_cmd_pkg::CMD_RD_DATA
                                             : adc_cmd_pkg::CMD_PAD;
        end
    end

    a_dv_single: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_adc_data_dv |=> !o_adc_data_dv
    );

endmodule

// File: rtl/spi_byte_engine.sv
module spi_byte_engine (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_tx_ready,
    input  logic [7:0]                 i_rx_byte,
    input  spi_link_pkg::byte_req_t    i_init_req,
    input  spi_link_pkg::byte_req_t    i_read_req,
    output spi_link_pkg::byte_rsp_t    o_init_rsp,
    output spi_link_pkg::byte_rsp_t    o_read_rsp,
    output spi_link_pkg::spi_mst_out_t o_spi
);

    typedef enum logic [2:0] {
        IDLE,
        FRAME_RST,
        LOAD,
        STROBE,
        WAIT_READY,
        DONE
    } state_e;

    state_e                  state;
    logic                    grant_read;
    logic [7:0]              rx_q;
    spi_link_pkg::byte_req_t pick_req;
    spi_link_pkg::byte_req_t cur_req;

    // sequencer has priority
    assign pick_req = i_init_req.valid ? i_init_req : i_read_req;
    assign cur_req  = grant_read ? i_read_req : i_init_req;

    ////////////////////////////////////////////////////////////
    // master handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state      <= IDLE;
            grant_read <= 1'b0;
            o_spi      <= '{rst_n: 1'b1, tx_count: 3'd0, tx_byte: 8'h00, tx_dv: 1'b0};
        end else begin
            case (state)
                IDLE: begin
                    if (i_init_req.valid || i_read_req.valid) begin
                        grant_read <= !i_init_req.valid;
                        if (pick_req.new_frame) begin
                            o_spi.rst_n <= 1'b0;
                            state       <= FRAME_RST;
                        end else begin
                            // same frame, count stays
                            o_spi.tx_byte <= pick_req.tx_byte;
                            state         <= LOAD;
                        end
                    end
                end
                FRAME_RST: begin
                    o_spi.rst_n    <= 1'b1;
                    o_spi.tx_count <= cur_req.frame_len;
                    o_spi.tx_byte  <= cur_req.tx_byte;
                    state          <= LOAD;
                end
                LOAD: begin
                    o_spi.tx_dv <= 1'b1;
                    state       <= STROBE;
                end
                STROBE: begin
                    o_spi.tx_dv <= 1'b0;
                    state       <= WAIT_READY;
                end
                WAIT_READY: begin
                    // no timeout, master may stall
                    if (i_tx_ready) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == WAIT_READY && i_tx_ready) begin
            rx_q <= i_rx_byte;
        end
    end

    assign o_init_rsp.done    = (state == DONE) && !grant_read;
    assign o_init_rsp.rx_byte = rx_q;
    assign o_read_rsp.done    = (state == DONE) && grant_read;
    assign o_read_rsp.rx_byte = rx_q;

    a_tx_dv_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_spi.tx_dv |=> !o_spi.tx_dv
    );

endmodule

// File: rtl/adc_ctrl_top.sv
module adc_ctrl_top #(
    parameter int SYNC_STAGES  = 2,
    parameter int SAMPLE_BYTES = 3
) (
    input  logic                       spi_clk,
    input  logic                       i_rst,
    input  logic                       i_en1,
    input  logic                       i_en2,
    input  logic                       i_rdyb,
    input  logic                       i_tx_ready,
    input  logic [7:0]                 i_rx_byte,
    output spi_link_pkg::spi_mst_out_t o_spi,
    output logic [8*SAMPLE_BYTES-1:0]  o_adc_data,
    output logic                       o_adc_data_dv
);

    logic                    rdyb_fall;
    logic                    init_busy;
    spi_link_pkg::byte_req_t init_req;
    spi_link_pkg::byte_req_t read_req;
    spi_link_pkg::byte_rsp_t init_rsp;
    spi_link_pkg::byte_rsp_t read_rsp;

    rdyb_edge_detect #(
        .SYNC_STAGES(SYNC_STAGES)
    ) edge_i (
        .i_clk  (spi_clk),
        .i_rst  (i_rst),
        .i_rdyb (i_rdyb),
        .o_fall (rdyb_fall)
    );

    adc_init_sequencer init_i (
        .i_clk   (spi_clk),
        .i_rst   (i_rst),
        .i_start (i_en1),
        .i_rsp   (init_rsp),
        .o_req   (init_req),
        .o_busy  (init_busy)
    );

    adc_sample_reader #(
        .SAMPLE_BYTES(SAMPLE_BYTES)
    ) reader_i (
        .i_clk         (spi_clk),
        .i_rst         (i_rst),
        .i_rdyb_fall   (rdyb_fall),
        .i_en          (i_en2),
        .i_init_busy   (init_busy),
        .i_rsp         (read_rsp),
        .o_req         (read_req),
        .o_adc_data    (o_adc_data),
        .o_adc_data_dv (o_adc_data_dv)
    );

    spi_byte_engine engine_i (
        .i_clk      (spi_clk),
        .i_rst      (i_rst),
        .i_tx_ready (i_tx_ready),
        .i_rx_byte  (i_rx_byte),
        .i_init_req (init_req),
        .i_read_req (read_req),
        .o_init_rsp (init_rsp),
        .o_read_rsp (read_rsp),
        .o_spi      (o_spi)
    );

endmodule

// File: tests/adc_checker.sv
module adc_checker (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  spi_link_pkg::spi_mst_out_t i_spi,
    input  logic [23:0]                i_adc_data,
    input  logic                       i_adc_data_dv
);

    localparam int CFG_N = 14;

    logic [11:0] pat [0:31];
    // {frame start, count digit, byte}
    logic [12:0] exp_tx [$];
    logic [23:0] exp_dv [$];
    int          errors = 0;
    int          tx_seen = 0;
    int          dv_seen = 0;
    logic        rst_seen = 1'b0;

    initial $readmemh("tests/adc_patterns.txt", pat);

    task automatic mismatch(input string name, input int expv, input int gotv);
        $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expv, gotv);
        errors++;
    endtask

    task automatic expect_config();
        int rem;
        rem = 0;
        for (int i = 0; i < CFG_N; i++) begin
            exp_tx.push_back({(rem == 0), pat[i]});
            if (rem == 0) begin
                rem = int'(pat[i][10:8]) - 1;
            end else begin
                rem--;
            end
        end
    endtask

    task automatic expect_sample(input int k);
        exp_tx.push_back({1'b1, 4'h4, 8'hDD});
        for (int i = 0; i < 3; i++) begin
            exp_tx.push_back({1'b0, 4'h4, 8'h00});
        end
        exp_dv.push_back({pat[CFG_N+3*k][7:0], pat[CFG_N+3*k+1][7:0], pat[CFG_N+3*k+2][7:0]});
    endtask

    task automatic check_idle();
        if (i_spi.rst_n !== 1'b1) mismatch("o_spi.rst_n", 1, int'(i_spi.rst_n));
        if (i_spi.tx_dv !== 1'b0) mismatch("o_spi.tx_dv", 0, int'(i_spi.tx_dv));
        if (i_adc_data_dv !== 1'b0) mismatch("o_adc_data_dv", 0, int'(i_adc_data_dv));
        if (i_adc_data !== 24'h0) mismatch("o_adc_data", 0, int'(i_adc_data));
    endtask

    task automatic check_drained();
        if (exp_tx.size() != 0) begin
            $display("%0d expected spi bytes were never strobed", exp_tx.size());
            errors++;
            exp_tx.delete();
        end
        if (exp_dv.size() != 0) begin
            $display("%0d expected samples were never announced", exp_dv.size());
            errors++;
            exp_dv.delete();
        end
    endtask

    always @(posedge i_clk) begin
        logic [12:0] e;
        logic [23:0] s;
        if (!i_rst) begin
            if (!i_spi.rst_n) begin
                rst_seen = 1'b1;
            end
            if (i_spi.tx_dv) begin
                tx_seen++;
                if (exp_tx.size() == 0) begin
                    $display("unexpected spi byte %02h strobed at %0t", i_spi.tx_byte, $time);
                    errors++;
                end else begin
                    e = exp_tx.pop_front();
                    if (i_spi.tx_byte !== e[7:0]) begin
                        mismatch("o_spi.tx_byte", int'(e[7:0]), int'(i_spi.tx_byte));
                    end
                    if (i_spi.tx_count !== e[10:8]) begin
                        mismatch("o_spi.tx_count", int'(e[10:8]), int'(i_spi.tx_count));
                    end
                    if (e[12] && !rst_seen) begin
                        $display("frame started at %0t without an rst_n pulse", $time);
                        errors++;
                    end
                end
                rst_seen = 1'b0;
            end
            if (i_adc_data_dv) begin
                dv_seen++;
                if (exp_dv.size() == 0) begin
                    $display("unexpected data valid pulse at %0t", $time);
                    errors++;
                end else begin
                    s = exp_dv.pop_front();
                    if (i_adc_data !== s) mismatch("o_adc_data", int'(s), int'(i_adc_data));
                end
            end
        end
    end

endmodule

// File: tests/tb_adc_ctrl.sv
module tb_adc_ctrl;

    localparam int CFG_N     = 14;
    localparam int SAMP_MAX  = 6;
    localparam int WAIT_MAX  = 3000;

    logic                       spi_clk = 1'b0;
    logic                       i_rst;
    logic                       i_en1;
    logic                       i_en2;
    logic                       i_rdyb;
    logic                       i_tx_ready;
    logic [7:0]                 i_rx_byte;
    spi_link_pkg::spi_mst_out_t o_spi;
    logic [23:0]                o_adc_data;
    logic                       o_adc_data_dv;

    logic [11:0] pat [0:31];
    logic [31:0] lfsr = 32'h88d3_4616;
    logic        rand_delay = 1'b0;
    int          samp_ptr = 0;
    int          samp_k = 0;
    int          err_before = 0;
    int          timeouts = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #4 spi_clk = ~spi_clk;

    adc_ctrl_top #(
        .SYNC_STAGES  (2),
        .SAMPLE_BYTES (3)
    ) dut_i (
        .spi_clk       (spi_clk),
        .i_rst         (i_rst),
        .i_en1         (i_en1),
        .i_en2         (i_en2),
        .i_rdyb        (i_rdyb),
        .i_tx_ready    (i_tx_ready),
        .i_rx_byte     (i_rx_byte),
        .o_spi         (o_spi),
        .o_adc_data    (o_adc_data),
        .o_adc_data_dv (o_adc_data_dv)
    );

    adc_checker chk_i (
        .i_clk         (spi_clk),
        .i_rst         (i_rst),
        .i_spi         (o_spi),
        .i_adc_data    (o_adc_data),
        .i_adc_data_dv (o_adc_data_dv)
    );

    ////////////////////////////////////////////////////////////
    // random delays
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // spi master model answering one strobed byte
    task automatic serve_byte(input logic [2:0] cnt, input logic [7:0] tx);
        int d;
        i_tx_ready <= 1'b0;
        if (rand_delay) begin
            take_bits(3, d);
            d = d + 1;
        end else begin
            d = 1;
        end
        repeat (d) @(posedge spi_clk);
        if (cnt == 3'd4 && tx == 8'h00 && samp_ptr < 3 * SAMP_MAX) begin
            i_rx_byte <= pat[CFG_N+samp_ptr][7:0];
            samp_ptr++;
        end else begin
            i_rx_byte <= 8'hA5;
        end
        i_tx_ready <= 1'b1;
    endtask

    initial begin
        forever begin
            @(posedge spi_clk);
            if (!i_rst && o_spi.tx_dv) begin
                serve_byte(o_spi.tx_count, o_spi.tx_byte);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // waits
    ////////////////////////////////////////////////////////////

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        timeouts++;
    endtask

    task automatic wait_tx(input int target);
        int n;
        n = 0;
        while (chk_i.tx_seen < target && n < WAIT_MAX) begin
            @(posedge spi_clk);
            n++;
        end
        if (n >= WAIT_MAX) report_timeout("spi byte strobes");
    endtask

    task automatic wait_dv(input int target);
        int n;
        n = 0;
        while (chk_i.dv_seen < target && n < WAIT_MAX) begin
            @(posedge spi_clk);
            n++;
        end
        if (n >= WAIT_MAX) report_timeout("a data valid pulse");
    endtask

    task automatic wait_init_idle();
        int n;
        n = 0;
        while (dut_i.init_busy && n < WAIT_MAX) begin
            @(posedge spi_clk);
            n++;
        end
        if (n >= WAIT_MAX) report_timeout("the end of configuration");
    endtask

    ////////////////////////////////////////////////////////////
    // test steps
    ////////////////////////////////////////////////////////////

    task automatic pulse_en1();
        @(posedge spi_clk);
        i_en1 <= 1'b1;
        @(posedge spi_clk);
        i_en1 <= 1'b0;
    endtask

    task automatic run_config();
        int start;
        start = chk_i.tx_seen;
        chk_i.expect_config();
        pulse_en1();
        wait_tx(start + CFG_N);
        wait_init_idle();
    endtask

    task automatic run_sample();
        int d0;
        d0 = chk_i.dv_seen;
        chk_i.expect_sample(samp_k);
        samp_k++;
        @(posedge spi_clk);
        i_rdyb <= 1'b0;
        wait_dv(d0 + 1);
        @(posedge spi_clk);
        i_rdyb <= 1'b1;
        repeat (4) @(posedge spi_clk);
    endtask

    task automatic finish_test(input string name);
        int total;
        chk_i.check_drained();
        total = chk_i.errors + timeouts;
        tests_run++;
        if (total == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
        err_before = total;
    endtask

    initial begin
        int start;
        i_rst      = 1'b1;
        i_en1      = 1'b0;
        i_en2      = 1'b0;
        i_rdyb     = 1'b1;
        i_tx_ready = 1'b1;
        i_rx_byte  = 8'h00;
        $readmemh("tests/adc_patterns.txt", pat);
        repeat (8) @(posedge spi_clk);
        i_rst <= 1'b0;
        repeat (2) @(posedge spi_clk);

        chk_i.check_idle();
        finish_test("reset_state");

        run_config();
        finish_test("configuration");

        @(posedge spi_clk);
        i_en2 <= 1'b1;
        run_sample();
        run_sample();
        finish_test("sample_read");

        rand_delay = 1'b1;
        run_config();
        run_sample();
        run_sample();
        finish_test("random_ready_delay");

        // fall in the middle of a read frame
        start = chk_i.tx_seen;
        chk_i.expect_sample(samp_k);
        samp_k++;
        @(posedge spi_clk);
        i_rdyb <= 1'b0;
        wait_tx(start + 2);
        i_rdyb <= 1'b1;
        repeat (3) @(posedge spi_clk);
        i_rdyb <= 1'b0;
        wait_dv(chk_i.dv_seen + 1);
        i_rdyb <= 1'b1;
        repeat (80) @(posedge spi_clk);

        // fall and second start pulse during configuration
        start = chk_i.tx_seen;
        chk_i.expect_config();
        pulse_en1();
        wait_tx(start + 3);
        i_rdyb <= 1'b0;
        pulse_en1();
        repeat (4) @(posedge spi_clk);
        i_rdyb <= 1'b1;
        wait_tx(start + CFG_N);
        wait_init_idle();
        repeat (60) @(posedge spi_clk);

        // fall with sampling disabled
        i_en2 <= 1'b0;
        repeat (2) @(posedge spi_clk);
        i_rdyb <= 1'b0;
        repeat (60) @(posedge spi_clk);
        i_rdyb <= 1'b1;
        repeat (4) @(posedge spi_clk);
        finish_test("ignored_edges");

        // sampling resumes once enabled again
        i_en2 <= 1'b1;
        run_sample();
        finish_test("sample_after_enable");

        repeat (10) @(posedge spi_clk);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, chk_i.errors + timeouts);
        if (chk_i.errors + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tests/adc_patterns.txt
// one word per entry: high digit is the spi count, low two digits the byte
// 14 config strobes, then six samples of three reply bytes each, msb first
2D0 203
2C2 20C
2C4 2A0
2C2 22C
2C6 23C
2C8 200
18F
1BF
012 345 678
09A BCD EF0
7F0 0FF 801
800 000 001
A5C 3E1 96B
FFF FFF FFE

// File: filelist.f
rtl/adc_cmd_pkg.sv
rtl/spi_link_pkg.sv
rtl/rdyb_edge_detect.sv
rtl/adc_init_sequencer.sv
rtl/adc_sample_reader.sv
rtl/spi_byte_engine.sv
rtl/adc_ctrl_top.sv
tests/adc_checker.sv
tests/tb_adc_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the adc controller testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_adc_ctrl -f filelist.f \
    -o sim_adc_ctrl > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_adc_ctrl > sim.log 2>&1
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log && echo "PASS" \
    || { echo "FAIL"; exit 1; }
